//--- logic/ks10Pkg.sv
package ks10Pkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////

   // Words are numbered 0 (MSB) to 35
   localparam int wordWidth    = 36;
   localparam int halfWidth    = wordWidth / 2;

   // Ramfile word address
   localparam int ramAddrWidth = 10;

   // Virtual address field of the VMA
   localparam int addrWidth    = 22;

   // Lowest addresses map onto the ACs
   localparam int acLimit      = 16;
   localparam int acNumWidth   = $clog2(acLimit);

   ////////////////////////////////////////////////////////////
   // Control word field codes
   ////////////////////////////////////////////////////////////

   // DBUS source select
   localparam logic [0:1] selFlags   = 2'b00;
   localparam logic [0:1] selDp      = 2'b01;
   localparam logic [0:1] selRamfile = 2'b10;
   localparam logic [0:1] selDbm     = 2'b11;

   // DBM source select
   localparam logic [0:1] dbmSwap    = 2'b00;
   localparam logic [0:1] dbmVma     = 2'b01;
   localparam logic [0:1] dbmMem     = 2'b10;
   localparam logic [0:1] dbmNum     = 2'b11;

   // Ramfile address source
   localparam logic       ramAc      = 1'b0;
   localparam logic       ramVma     = 1'b1;

   // Microaddresses where an AC reference leaves the DBM alone
   localparam logic [0:11] forceExceptA = 12'o1146;
   localparam logic [0:11] forceExceptB = 12'o3666;

   ////////////////////////////////////////////////////////////
   // Structured types
   ////////////////////////////////////////////////////////////

   // Left and right halves of a data word
   typedef struct packed {
      logic [0:halfWidth-1] left;
      logic [0:halfWidth-1] right;
   } halfPair;

   // Data word, raw or split into halves
   typedef union packed {
      logic [0:wordWidth-1] raw;
      halfPair              halves;
   } dataWord;

   // Control ROM fields seen by the data bus path
   typedef struct packed {
      logic [0:11] jAddr;
      logic [0:1]  dbusSel;
      logic [0:1]  dbmSel;
      logic        vmaLoad;
      logic        vmaInc;
      logic        vmaRead;
      logic        vmaWrite;
      logic        vmaPhys;
      logic        ramWrite;
      logic        ramAddrSel;
      // Immediate number field
      logic [0:8]  number;
   } cromWord;

   // VMA register layout
   typedef struct packed {
      logic                                 user;
      logic                                 read;
      logic                                 write;
      logic                                 phys;
      logic [4:13]                          reserved;
      logic [wordWidth-addrWidth:wordWidth-1] address;
   } vmaWord;

endpackage

//--- logic/vmaRegister.sv
`timescale 1ns/1ps

module vmaRegister
(
   input  logic             clk,
   input  logic             rstN,
   input  ks10Pkg::cromWord crom,
   input  ks10Pkg::dataWord dp,
   output ks10Pkg::vmaWord  vmaReg,
   output logic             acRef
);

   import ks10Pkg::*;

   ////////////////////////////////////////////////////////////
   // VMA register
   ////////////////////////////////////////////////////////////

   // Next VMA value
   vmaWord vmaNext;

   always_comb
   begin
      vmaNext = vmaReg;
      if (crom.vmaLoad)
      begin
         // Load clears the flags that the control word does not set
         vmaNext          = '0;
         vmaNext.read     = crom.vmaRead;
         vmaNext.write    = crom.vmaWrite;
         vmaNext.phys     = crom.vmaPhys;
         // Address from the right of the datapath word
         vmaNext.address  = dp.raw[wordWidth-addrWidth:wordWidth-1];
      end
      else if (crom.vmaInc)
      begin
         // Flags hold, address wraps
         vmaNext.address  = vmaReg.address + addrWidth'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         vmaReg <= '0;
      end
      else
      begin
         vmaReg <= vmaNext;
      end
   end

   // AC reference
   // Low 16 words and not a physical reference
   assign acRef = (vmaReg.address < addrWidth'(acLimit)) && !vmaReg.phys;

   // Load and increment strobes are exclusive in the microcode
   loadIncExclusive : assert property (
      @(posedge clk) disable iff (!rstN) !(crom.vmaLoad && crom.vmaInc));

endmodule

//--- logic/ramfile.sv
`timescale 1ns/1ps

module ramfile
(
   input  logic             clk,
   input  ks10Pkg::cromWord crom,
   input  ks10Pkg::vmaWord  vmaReg,
   input  ks10Pkg::dataWord dbus,
   output ks10Pkg::dataWord ramData
);

   import ks10Pkg::*;

   ////////////////////////////////////////////////////////////
   // Address select
   ////////////////////////////////////////////////////////////

   // AC number from the low bits of the number field
   logic [0:acNumWidth-1]   acNum;

   // Word address into the store
   logic [0:ramAddrWidth-1] ramAddr;

   assign acNum = acNumWidth'(crom.number);

   always_comb
   begin
      case (crom.ramAddrSel)
         ramAc:
         begin
            // ACs live at the bottom of the store
            ramAddr = ramAddrWidth'(acNum);
         end
         ramVma:
         begin
            // Cache lines indexed by the low VMA bits
            ramAddr = ramAddrWidth'(vmaReg.address);
         end
         default:
         begin
            ramAddr = '0;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   // 1024 words of AC and cache data
   dataWord ramArray [0:2**ramAddrWidth-1];

   // Write the DBUS on the clock edge
   always_ff @(posedge clk)
   begin
      if (crom.ramWrite)
      begin
         ramArray[ramAddr] <= dbus;
      end
   end

   // Read is asynchronous
   assign ramData = ramArray[ramAddr];

   // The VMA feeding the address must be settled on a write
   writeAddrKnown : assert property (
      @(posedge clk) crom.ramWrite |-> !$isunknown(ramAddr));

endmodule

//--- logic/dbmMux.sv
`timescale 1ns/1ps

module dbmMux
(
   input  ks10Pkg::cromWord crom,
   input  ks10Pkg::dataWord dp,
   input  ks10Pkg::dataWord memData,
   input  ks10Pkg::vmaWord  vmaReg,
   output ks10Pkg::dataWord dbm
);

   import ks10Pkg::*;

   ////////////////////////////////////////////////////////////
   // DBM sources
   ////////////////////////////////////////////////////////////

   // Datapath with left and right swapped
   dataWord swapWord;

   // Number field copied into both halves
   dataWord numWord;

   // VMA seen as a plain data word
   dataWord vmaData;

   always_comb
   begin
      swapWord.halves.left  = dp.halves.right;
      swapWord.halves.right = dp.halves.left;
   end

   always_comb
   begin
      // Zero extend the 9 bit number
      numWord.halves.left  = halfWidth'(crom.number);
      numWord.halves.right = halfWidth'(crom.number);
   end

   // VMA goes out as stored, flags included
   assign vmaData.raw = vmaReg;

   ////////////////////////////////////////////////////////////
   // Four way select
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (crom.dbmSel)
         dbmSwap:
         begin
            dbm = swapWord;
         end
         dbmVma:
         begin
            dbm = vmaData;
         end
         dbmMem:
         begin
            // Memory bus read data
            dbm = memData;
         end
         dbmNum:
         begin
            dbm = numWord;
         end
         default:
         begin
            dbm = memData;
         end
      endcase
   end

endmodule

//--- logic/dbusMux.sv
`timescale 1ns/1ps

module dbusMux
(
   input  logic             clk,
   input  logic             rstN,
   input  ks10Pkg::cromWord crom,
   input  logic             cacheHit,
   input  logic             acRef,
   input  logic [0:2]       piReqPri,
   input  logic [0:17]      pcFlags,
   input  ks10Pkg::vmaWord  vmaReg,
   input  ks10Pkg::dataWord dp,
   input  ks10Pkg::dataWord ramData,
   input  ks10Pkg::dataWord dbm,
   output ks10Pkg::dataWord dbus
);

   import ks10Pkg::*;

   ////////////////////////////////////////////////////////////
   // Force ramfile
   ////////////////////////////////////////////////////////////

   // Read cycle that hits the ACs or the cache
   logic forceRamfile;

   // Microaddress is one of the two AC exceptions
   logic forceExcept;

   assign forceExcept = (crom.jAddr == forceExceptA) || (crom.jAddr == forceExceptB);

   // AC reads outside the exceptions, or any cache hit read
   assign forceRamfile = (acRef && vmaReg.read && !forceExcept) ||
                         (cacheHit && vmaReg.read);

   ////////////////////////////////////////////////////////////
   // DBUS select
   ////////////////////////////////////////////////////////////

   // Flags word
   dataWord flagsWord;

   // PC flags, zero, PI level, four ones, low VMA bits
   assign flagsWord.raw = {pcFlags, 1'b0, piReqPri, 4'b1111, vmaReg.address[26:35]};

   always_comb
   begin
      case (crom.dbusSel)
         selFlags:
         begin
            dbus = flagsWord;
         end
         selDp:
         begin
            dbus = dp;
         end
         selRamfile:
         begin
            dbus = ramData;
         end
         selDbm:
         begin
            // Ramfile replaces memory on a forced read
            dbus = forceRamfile ? ramData : dbm;
         end
         default:
         begin
            dbus = dp;
         end
      endcase
   end

   // Every selected source is driven once out of reset
   dbusKnown : assert property (
      @(posedge clk) disable iff (!rstN) !$isunknown(dbus));

endmodule

//--- logic/dbusPath.sv
`timescale 1ns/1ps

module dbusPath
(
   input  logic             clk,
   input  logic             rstN,
   input  ks10Pkg::cromWord crom,
   input  logic             cacheHit,
   input  logic [0:2]       piReqPri,
   input  logic [0:17]      pcFlags,
   input  ks10Pkg::dataWord dp,
   input  ks10Pkg::dataWord memData,
   output ks10Pkg::dataWord dbus,
   output ks10Pkg::vmaWord  vmaReg
);

   import ks10Pkg::*;

   ////////////////////////////////////////////////////////////
   // Internal wiring
   ////////////////////////////////////////////////////////////

   // Low address and not physical
   logic    acRef;

   // Ramfile read data
   dataWord ramData;

   // DBM output
   dataWord dbm;

   // VMA register and AC decode
   vmaRegister vmaRegister_inst
   (
      .clk     (clk),
      .rstN    (rstN),
      .crom    (crom),
      .dp      (dp),
      .vmaReg  (vmaReg),
      .acRef   (acRef)
   );

   // AC and cache store, written back from the DBUS
   ramfile ramfile_inst
   (
      .clk     (clk),
      .crom    (crom),
      .vmaReg  (vmaReg),
      .dbus    (dbus),
      .ramData (ramData)
   );

   // Data bus mux
   dbmMux dbmMux_inst
   (
      .crom    (crom),
      .dp      (dp),
      .memData (memData),
      .vmaReg  (vmaReg),
      .dbm     (dbm)
   );

   dbusMux dbusMux_inst
   (
      .clk      (clk),
      .rstN     (rstN),
      .crom     (crom),
      .cacheHit (cacheHit),
      .acRef    (acRef),
      .piReqPri (piReqPri),
      .pcFlags  (pcFlags),
      .vmaReg   (vmaReg),
      .dp       (dp),
      .ramData  (ramData),
      .dbm      (dbm),
      .dbus     (dbus)
   );

endmodule

//--- tb/dbusPathRef.svh
`ifndef DBUSPATHREF_SVH
`define DBUSPATHREF_SVH

////////////////////////////////////////////////////////////
// Model state, advanced on each rising edge
////////////////////////////////////////////////////////////

vmaWord      modelVma;
logic [0:35] modelRam [0:1023];

// Fill pattern built from all ten address bits
function automatic logic [0:35] fillWord(input logic [0:9] addr);
   return {addr, ~addr, addr ^ 10'h2b5, 6'(addr * 10'd7)};
endfunction

// Word address, AC number or low VMA bits
function automatic logic [0:9] ramAddrRef(input cromWord c, input vmaWord v);
   if (c.ramAddrSel == ramVma)
      return v.address[26:35];
   return {6'b000000, c.number[5:8]};
endfunction

// Read cycle that hits an AC outside the exceptions, or the cache
function automatic logic forceRef(input cromWord c, input vmaWord v, input logic hit);
   logic acHit;
   logic excepted;
   acHit    = (v.address < 22'd16) && !v.phys;
   excepted = (c.jAddr == 12'o1146) || (c.jAddr == 12'o3666);
   return v.read && ((acHit && !excepted) || hit);
endfunction

function automatic logic [0:35] dbmRef(input cromWord c, input vmaWord v,
                                       input logic [0:35] dpVal, input logic [0:35] memVal);
   case (c.dbmSel)
      dbmSwap: return {dpVal[18:35], dpVal[0:17]};
      dbmVma:  return v;
      dbmMem:  return memVal;
      default: return {9'b0, c.number, 9'b0, c.number};
   endcase
endfunction

// Expected DBUS for the current inputs and model state
function automatic logic [0:35] dbusRef(input cromWord c, input vmaWord v,
                                        input logic [0:35] dpVal, input logic [0:35] memVal,
                                        input logic [0:17] pcf, input logic [0:2] pri,
                                        input logic hit);
   logic [0:35] ramWord;
   ramWord = modelRam[ramAddrRef(c, v)];
   case (c.dbusSel)
      selFlags:   return {pcf, 1'b0, pri, 4'b1111, v.address[26:35]};
      selDp:      return dpVal;
      selRamfile: return ramWord;
      default:    return forceRef(c, v, hit) ? ramWord : dbmRef(c, v, dpVal, memVal);
   endcase
endfunction

function automatic vmaWord vmaNextRef(input cromWord c, input vmaWord v,
                                      input logic [0:35] dpVal);
   vmaWord n;
   n = v;
   if (c.vmaLoad)
   begin
      n         = '0;
      n.read    = c.vmaRead;
      n.write   = c.vmaWrite;
      n.phys    = c.vmaPhys;
      n.address = dpVal[14:35];
   end
   else if (c.vmaInc)
      n.address = v.address + 22'd1;
   return n;
endfunction

`endif

//--- tb/dbusPathTb.sv
`timescale 1ns/1ps

module dbusPathTb;

   import ks10Pkg::*;

   `include "dbusPathRef.svh"

   localparam int clkPeriod  = 100;
   localparam int resetLimit = 8;
   localparam int runCycles  = 3000;

   logic        clk;
   logic        rstN;
   cromWord     crom;
   logic        cacheHit;
   logic [0:2]  piReqPri;
   logic [0:17] pcFlags;
   dataWord     dp;
   dataWord     memData;
   dataWord     dbus;
   vmaWord      vmaReg;

   // Compare only once reset has settled
   logic        checkEnable;

   dbusPath dbusPath_inst
   (
      .clk      (clk),
      .rstN     (rstN),
      .crom     (crom),
      .cacheHit (cacheHit),
      .piReqPri (piReqPri),
      .pcFlags  (pcFlags),
      .dp       (dp),
      .memData  (memData),
      .dbus     (dbus),
      .vmaReg   (vmaReg)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(clkPeriod / 2);
         clk = ~clk;
      end
   end

   ////////////////////////////////////////////////////////////
   // Failure reporting
   ////////////////////////////////////////////////////////////

   task automatic abortRun();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic reportMismatch(input string what, input logic [0:35] got,
                                 input logic [0:35] exp);
      $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
      abortRun();
   endtask

   task automatic reportFailure(input string reason);
      $display("error at %0d ns: %s", $time, reason);
      abortRun();
   endtask

   ////////////////////////////////////////////////////////////
   // Model update and comparison
   ////////////////////////////////////////////////////////////

   // Ramfile write uses the VMA from before the edge
   always @(posedge clk)
   begin
      if (crom.ramWrite)
         modelRam[ramAddrRef(crom, modelVma)] = dbusRef(crom, modelVma, dp.raw, memData.raw,
                                                        pcFlags, piReqPri, cacheHit);
      if (!rstN)
         modelVma = '0;
      else
         modelVma = vmaNextRef(crom, modelVma, dp.raw);
   end

   // Sample a quarter period before the rising edge
   initial
   begin
      logic [0:35] expDbus;
      forever
      begin
         @(negedge clk);
         #(clkPeriod / 4);
         if (checkEnable)
         begin
            expDbus = dbusRef(crom, modelVma, dp.raw, memData.raw, pcFlags, piReqPri, cacheHit);
            assert (dbus.raw === expDbus) else reportMismatch("dbus", dbus.raw, expDbus);
            assert (vmaReg === modelVma) else reportMismatch("vmaReg", vmaReg, modelVma);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   // Apply one control word, then move to the next falling edge
   task automatic driveCycle(input cromWord c, input logic [0:35] dpVal, input logic hit);
      crom        = c;
      dp.raw      = dpVal;
      cacheHit    = hit;
      memData.raw = 36'({$urandom, $urandom});
      pcFlags     = 18'($urandom);
      piReqPri    = 3'($urandom);
      @(negedge clk);
   endtask

   // Load and increment never together
   function automatic cromWord randomCrom();
      cromWord    c;
      logic [0:1] op;
      c         = cromWord'($urandom);
      op        = 2'($urandom);
      c.vmaLoad = (op == 2'd1);
      c.vmaInc  = (op == 2'd2);
      c.vmaPhys = ($urandom % 4 == 0);
      // Exception addresses often
      case ($urandom % 4)
         0: c.jAddr = forceExceptA;
         1: c.jAddr = forceExceptB;
         default: ;
      endcase
      return c;
   endfunction

   initial
   begin
      cromWord     c;
      logic [0:35] dpVal;
      int          waitCount;
      int          cycle;
      void'($urandom(32'hb5919810));
      rstN        = 1'b0;
      crom        = '0;
      cacheHit    = 1'b0;
      piReqPri    = '0;
      pcFlags     = '0;
      dp          = '0;
      memData     = '0;
      checkEnable = 1'b0;

      // Reset low for two clocks, VMA must read zero
      repeat (2) @(negedge clk);
      waitCount = 0;
      while (vmaReg !== '0)
      begin
         assert (waitCount < resetLimit) else reportFailure("vmaReg did not clear in reset");
         @(negedge clk);
         waitCount++;
      end
      rstN        = 1'b1;
      checkEnable = 1'b1;

      // Fill every ramfile word through the DP path
      c         = '0;
      c.vmaLoad = 1'b1;
      driveCycle(c, '0, 1'b0);
      c            = '0;
      c.dbusSel    = selDp;
      c.vmaInc     = 1'b1;
      c.ramWrite   = 1'b1;
      c.ramAddrSel = ramVma;
      for (int i = 0; i < 1024; i++)
         driveCycle(c, fillWord(10'(i)), 1'b0);

      // Load near the top with read set, then wrap into AC 0
      c         = '0;
      c.vmaLoad = 1'b1;
      c.vmaRead = 1'b1;
      driveCycle(c, 36'h3ffffe, 1'b0);
      c        = '0;
      c.vmaInc = 1'b1;
      driveCycle(c, '0, 1'b0);
      driveCycle(c, '0, 1'b0);

      // DBM reads at AC 0 at both exceptions and a plain address
      c         = '0;
      c.dbusSel = selDbm;
      c.dbmSel  = dbmMem;
      c.jAddr   = forceExceptA;
      driveCycle(c, '0, 1'b0);
      c.jAddr = forceExceptB;
      driveCycle(c, '0, 1'b0);
      driveCycle(c, '0, 1'b1);
      c.jAddr = 12'o0100;
      driveCycle(c, '0, 1'b0);

      // Random cycles, small addresses half the time
      cycle = 0;
      while (cycle < runCycles)
      begin
         dpVal = 36'({$urandom, $urandom});
         if ($urandom % 2 == 0)
            dpVal[14:35] = 22'($urandom % 24);
         driveCycle(randomCrom(), dpVal, 1'($urandom));
         cycle++;
      end

      $display("sim passed");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+tb
logic/ks10Pkg.sv
logic/vmaRegister.sv
logic/ramfile.sv
logic/dbmMux.sv
logic/dbusMux.sv
logic/dbusPath.sv
tb/dbusPathTb.sv

//--- run.sh
#!/bin/sh
# Build and run the dbusPath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module dbusPathTb -f filelist.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build returned status $status"
   exit $status
fi

./obj_dir/VdbusPathTb
status=$?
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit $status
fi

exit 0
